// ==== hw/pipe_consts.svh ====
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// one bit per pipeline register, PC up to the WB slot
`define PIPE_VEC_W 6

// cycles a mul/div instruction keeps EX occupied
`define MULDIV_LATENCY 4

`endif

// ==== hw/pipe_types_pkg.sv ====
package pipe_types_pkg;

  // widths seen by the datapath side of the core

  typedef logic [31:0] pc_t;       // instruction address
  typedef logic [4:0]  reg_idx_t;  // x0..x31

endpackage

// ==== hw/pipe_ctrl_pkg.sv ====
`include "pipe_consts.svh"

package pipe_ctrl_pkg;

  typedef logic [`PIPE_VEC_W-1:0] stage_vec_t;  // stall / flush request per register

  // bit positions inside stage_vec_t
  localparam int stg_pc    = 0;
  localparam int stg_ifid  = 1;
  localparam int stg_idex  = 2;
  localparam int stg_exmem = 3;
  localparam int stg_memwb = 4;
  localparam int stg_wb    = 5;  // write-back slot, no register behind it

  // mul/div sequencer
  typedef enum logic [1:0] {
    MDU_IDLE,
    MDU_BUSY,
    MDU_DONE
  } mdu_state_e;

endpackage

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
  input  logic                      rst,
  input  logic                      mem_wait_i,    // data memory not ready
  input  logic                      if_wait_i,     // fetch not ready
  input  logic                      trap_flush_i,
  input  logic                      trap_stall_i,
  input  logic                      jump_ex_i,     // taken branch/jump resolved in EX
  input  logic                      mdu_busy_i,
  input  logic                      load_use_i,
  output pipe_ctrl_pkg::stage_vec_t stall_o,
  output pipe_ctrl_pkg::stage_vec_t flush_o
);
  import pipe_ctrl_pkg::*;

  // single-bit masks
  localparam stage_vec_t b_pc    = stage_vec_t'(1) << stg_pc;
  localparam stage_vec_t b_ifid  = stage_vec_t'(1) << stg_ifid;
  localparam stage_vec_t b_idex  = stage_vec_t'(1) << stg_idex;
  localparam stage_vec_t b_exmem = stage_vec_t'(1) << stg_exmem;
  localparam stage_vec_t b_memwb = stage_vec_t'(1) << stg_memwb;
  localparam stage_vec_t b_wb    = stage_vec_t'(1) << stg_wb;

  localparam stage_vec_t rst_flush = b_pc | b_ifid | b_idex | b_exmem | b_memwb;

  localparam stage_vec_t mem_wait_stall   = b_pc | b_ifid | b_idex | b_exmem;
  localparam stage_vec_t mem_wait_flush   = b_memwb;  // the load/store in MEM cannot retire
  localparam stage_vec_t if_wait_stall    = b_pc | b_ifid | b_idex | b_exmem;
  localparam stage_vec_t if_wait_flush    = '0;
  localparam stage_vec_t trap_flush_stall = b_ifid;
  localparam stage_vec_t trap_flush_flush = b_ifid | b_idex | b_exmem;
  localparam stage_vec_t trap_stall_stall = b_pc | b_ifid | b_idex | b_exmem | b_memwb | b_wb;
  localparam stage_vec_t trap_stall_flush = b_ifid | b_idex | b_exmem;
  localparam stage_vec_t jump_stall       = b_ifid;
  localparam stage_vec_t jump_flush       = b_ifid | b_idex;  // two younger tags dropped
  localparam stage_vec_t mul_div_stall    = b_pc | b_ifid | b_idex;
  localparam stage_vec_t mul_div_flush    = b_exmem;
  localparam stage_vec_t load_use_stall   = b_pc | b_ifid;
  localparam stage_vec_t load_use_flush   = b_idex;  // one bubble behind the load

  // later stage wins, so memory back-pressure sits on top
  always_comb begin
    if (rst) begin
      stall_o = '0;
      flush_o = rst_flush;
    end else if (mem_wait_i) begin
      stall_o = mem_wait_stall;
      flush_o = mem_wait_flush;
    end else if (if_wait_i) begin
      stall_o = if_wait_stall;
      flush_o = if_wait_flush;
    end else if (trap_flush_i) begin
      stall_o = trap_flush_stall;
      flush_o = trap_flush_flush;
    end else if (trap_stall_i) begin
      stall_o = trap_stall_stall;
      flush_o = trap_stall_flush;
    end else if (jump_ex_i) begin
      stall_o = jump_stall;
      flush_o = jump_flush;
    end else if (mdu_busy_i) begin
      stall_o = mul_div_stall;
      flush_o = mul_div_flush;
    end else if (load_use_i) begin
      stall_o = load_use_stall;
      flush_o = load_use_flush;
    end else begin
      stall_o = '0;
      flush_o = '0;
    end
  end

endmodule

// ==== hw/mul_div_sequencer.sv ====
`timescale 1ns/1ps
`include "pipe_consts.svh"

module mul_div_sequencer (
  input  logic clk,
  input  logic rst,
  input  logic ex_muldiv_i,  // valid mul/div tag in ID/EX
  input  logic stall_ex_i,   // EX/MEM stall bit, older hazard freezing EX
  output logic busy_o
);
  import pipe_ctrl_pkg::*;

  localparam int cnt_w = $clog2(`MULDIV_LATENCY);

  mdu_state_e       state_q;
  mdu_state_e       state_d;
  logic [cnt_w-1:0] cnt_q;
  logic [cnt_w-1:0] cnt_d;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      MDU_IDLE: begin
        if (ex_muldiv_i) begin
          state_d = MDU_BUSY;
          cnt_d   = cnt_w'(`MULDIV_LATENCY - 1);  // this cycle already counts
        end
      end
      MDU_BUSY: begin
        if (!ex_muldiv_i) begin
          state_d = MDU_IDLE;  // flushed out of EX
        end else if (!stall_ex_i) begin
          cnt_d = cnt_q - 1'b1;
          if (cnt_q == cnt_w'(1)) begin
            state_d = MDU_DONE;
          end
        end
      end
      MDU_DONE: begin
        // stay put while EX is frozen, else the same tag would restart
        if (!ex_muldiv_i || !stall_ex_i) begin
          state_d = MDU_IDLE;
        end
      end
      default: state_d = MDU_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= MDU_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // rises with the tag, drops in DONE so the result can leave EX
  assign busy_o = ex_muldiv_i && (state_q != MDU_DONE);

  a_busy_bounded: assert property (@(posedge clk) disable iff (rst)
    $rose(busy_o) ##0 (busy_o && !stall_ex_i) [*`MULDIV_LATENCY] |=> !busy_o);

endmodule

// ==== hw/stage_tracker.sv ====
`timescale 1ns/1ps

module stage_tracker (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      if_valid_i,
  input  pipe_types_pkg::pc_t       if_pc_i,
  input  logic                      if_is_load_i,
  input  logic                      if_is_muldiv_i,
  input  pipe_types_pkg::reg_idx_t  if_rs1_i,
  input  pipe_types_pkg::reg_idx_t  if_rs2_i,
  input  pipe_types_pkg::reg_idx_t  if_rd_i,
  input  pipe_ctrl_pkg::stage_vec_t stall_i,
  input  pipe_ctrl_pkg::stage_vec_t flush_i,
  output logic                      load_use_o,
  output logic                      ex_muldiv_o,
  output logic                      wb_valid_o,
  output pipe_types_pkg::pc_t       wb_pc_o
);
  import pipe_types_pkg::*;
  import pipe_ctrl_pkg::*;

  // valid + pc for every register, IF/ID through MEM/WB
  logic vld_q [stg_ifid:stg_memwb];
  logic vld_d [stg_ifid:stg_memwb];
  pc_t  pc_q  [stg_ifid:stg_memwb];
  pc_t  pc_d  [stg_ifid:stg_memwb];

  // decode fields only matter up to ID/EX
  logic     ifid_ld;
  logic     ifid_md;
  reg_idx_t ifid_rs1;
  reg_idx_t ifid_rs2;
  reg_idx_t ifid_rd;
  logic     idex_ld;
  logic     idex_md;
  reg_idx_t idex_rd;

  always_comb begin
    vld_d[stg_ifid] = if_valid_i && !stall_i[stg_pc];
    pc_d[stg_ifid]  = if_pc_i;
    for (int s = stg_ifid + 1; s <= stg_memwb; s++) begin
      vld_d[s] = vld_q[s-1] && !stall_i[s-1];  // upstream held, take a bubble
      pc_d[s]  = pc_q[s-1];
    end
  end

  // flush beats stall on the valid bit, payload only moves when not stalled
  always_ff @(posedge clk) begin
    for (int s = stg_ifid; s <= stg_memwb; s++) begin
      if (rst || flush_i[s]) begin
        vld_q[s] <= 1'b0;
      end else if (!stall_i[s]) begin
        vld_q[s] <= vld_d[s];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int s = stg_ifid; s <= stg_memwb; s++) begin
      if (!stall_i[s]) begin
        pc_q[s] <= pc_d[s];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i[stg_ifid]) begin
      ifid_ld  <= if_is_load_i;
      ifid_md  <= if_is_muldiv_i;
      ifid_rs1 <= if_rs1_i;
      ifid_rs2 <= if_rs2_i;
      ifid_rd  <= if_rd_i;
    end
    if (!stall_i[stg_idex]) begin
      idex_ld <= ifid_ld;
      idex_md <= ifid_md;
      idex_rd <= ifid_rd;
    end
  end

  // load in EX feeding the instruction in ID, x0 never counts
  assign load_use_o = vld_q[stg_idex] && idex_ld && (idex_rd != '0) && vld_q[stg_ifid] &&
                      ((idex_rd == ifid_rs1) || (idex_rd == ifid_rs2));

  assign ex_muldiv_o = vld_q[stg_idex] && idex_md;

  assign wb_valid_o = vld_q[stg_memwb] && !stall_i[stg_wb];  // no retire while WB held
  assign wb_pc_o    = pc_q[stg_memwb];

  // a load-use hit lasts one cycle unless ID/EX itself is held
  a_load_use_one_cycle: assert property (@(posedge clk) disable iff (rst)
    load_use_o && !stall_i[stg_idex] |=> !load_use_o);

endmodule

// ==== hw/pipeline_ctrl_top.sv ====
`timescale 1ns/1ps

module pipeline_ctrl_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      if_valid_i,
  input  pipe_types_pkg::pc_t       if_pc_i,
  input  logic                      if_is_load_i,
  input  logic                      if_is_muldiv_i,
  input  pipe_types_pkg::reg_idx_t  if_rs1_i,
  input  pipe_types_pkg::reg_idx_t  if_rs2_i,
  input  pipe_types_pkg::reg_idx_t  if_rd_i,
  input  logic                      mem_wait_i,
  input  logic                      if_wait_i,
  input  logic                      trap_flush_i,
  input  logic                      trap_stall_i,
  input  logic                      jump_ex_i,
  output pipe_ctrl_pkg::stage_vec_t stall_o,
  output pipe_ctrl_pkg::stage_vec_t flush_o,
  output logic                      wb_valid_o,
  output pipe_types_pkg::pc_t       wb_pc_o
);
  import pipe_ctrl_pkg::*;

  logic load_use_hit;
  logic ex_muldiv;
  logic mdu_busy;

  stage_tracker u_tracker (
    .clk            (clk),
    .rst            (rst),
    .if_valid_i     (if_valid_i),
    .if_pc_i        (if_pc_i),
    .if_is_load_i   (if_is_load_i),
    .if_is_muldiv_i (if_is_muldiv_i),
    .if_rs1_i       (if_rs1_i),
    .if_rs2_i       (if_rs2_i),
    .if_rd_i        (if_rd_i),
    .stall_i        (stall_o),
    .flush_i        (flush_o),
    .load_use_o     (load_use_hit),
    .ex_muldiv_o    (ex_muldiv),
    .wb_valid_o     (wb_valid_o),
    .wb_pc_o        (wb_pc_o)
  );

  // EX/MEM bit only, older hazards never set it through mdu_busy
  mul_div_sequencer u_mdu (
    .clk         (clk),
    .rst         (rst),
    .ex_muldiv_i (ex_muldiv),
    .stall_ex_i  (stall_o[stg_exmem]),
    .busy_o      (mdu_busy)
  );

  hazard_unit u_hazard (
    .rst          (rst),
    .mem_wait_i   (mem_wait_i),
    .if_wait_i    (if_wait_i),
    .trap_flush_i (trap_flush_i),
    .trap_stall_i (trap_stall_i),
    .jump_ex_i    (jump_ex_i),
    .mdu_busy_i   (mdu_busy),
    .load_use_i   (load_use_hit),
    .stall_o      (stall_o),
    .flush_o      (flush_o)
  );

endmodule

// ==== tb/pipeline_ctrl_tb.sv ====
`timescale 1ns/1ps

module pipeline_ctrl_tb;

  localparam int max_lines = 200;  // upper bound on trace lines read

  logic        clk;
  logic        rst;
  logic        if_valid_i;
  logic [31:0] if_pc_i;
  logic        if_is_load_i;
  logic        if_is_muldiv_i;
  logic [4:0]  if_rs1_i;
  logic [4:0]  if_rs2_i;
  logic [4:0]  if_rd_i;
  logic        mem_wait_i;
  logic        if_wait_i;
  logic        trap_flush_i;
  logic        trap_stall_i;
  logic        jump_ex_i;
  logic [5:0]  stall_o;
  logic [5:0]  flush_o;
  logic        wb_valid_o;
  logic [31:0] wb_pc_o;

  int errors;
  int checks;

  pipeline_ctrl_top UUT (
    .clk            (clk),
    .rst            (rst),
    .if_valid_i     (if_valid_i),
    .if_pc_i        (if_pc_i),
    .if_is_load_i   (if_is_load_i),
    .if_is_muldiv_i (if_is_muldiv_i),
    .if_rs1_i       (if_rs1_i),
    .if_rs2_i       (if_rs2_i),
    .if_rd_i        (if_rd_i),
    .mem_wait_i     (mem_wait_i),
    .if_wait_i      (if_wait_i),
    .trap_flush_i   (trap_flush_i),
    .trap_stall_i   (trap_stall_i),
    .jump_ex_i      (jump_ex_i),
    .stall_o        (stall_o),
    .flush_o        (flush_o),
    .wb_valid_o     (wb_valid_o),
    .wb_pc_o        (wb_pc_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  task automatic compare_vectors(input logic [5:0] exp_stall, input logic [5:0] exp_flush,
                                 input logic exp_wb_valid, input logic [31:0] exp_wb_pc);
    checks++;
    assert (stall_o === exp_stall) else begin
      errors++;
      $display("[FAIL] %0t ns: stall_o %h, expected %h (errors %0d)",
               $time, stall_o, exp_stall, errors);
    end
    assert (flush_o === exp_flush) else begin
      errors++;
      $display("[FAIL] %0t ns: flush_o %h, expected %h (errors %0d)",
               $time, flush_o, exp_flush, errors);
    end
    assert (wb_valid_o === exp_wb_valid) else begin
      errors++;
      $display("[FAIL] %0t ns: wb_valid_o %b, expected %b (errors %0d)",
               $time, wb_valid_o, exp_wb_valid, errors);
    end
    // pc only meaningful on a retiring slot
    if (exp_wb_valid) begin
      assert (wb_pc_o === exp_wb_pc) else begin
        errors++;
        $display("[FAIL] %0t ns: wb_pc_o %h, expected %h (errors %0d)",
                 $time, wb_pc_o, exp_wb_pc, errors);
      end
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          guard;
    bit          timed_out;
    string       line;
    logic        v;
    logic        ld;
    logic        md;
    logic [31:0] pc;
    int          rs1;
    int          rs2;
    int          rd;
    logic        mw;
    logic        iw;
    logic        tf;
    logic        ts;
    logic        jp;
    logic [5:0]  exp_stall;
    logic [5:0]  exp_flush;
    logic        exp_wb_valid;
    logic [31:0] exp_wb_pc;

    errors         = 0;
    checks         = 0;
    guard          = 0;
    timed_out      = 1'b0;
    rst            = 1'b1;
    if_valid_i     = 1'b0;
    if_pc_i        = '0;
    if_is_load_i   = 1'b0;
    if_is_muldiv_i = 1'b0;
    if_rs1_i       = '0;
    if_rs2_i       = '0;
    if_rd_i        = '0;
    mem_wait_i     = 1'b0;
    if_wait_i      = 1'b0;
    trap_flush_i   = 1'b0;
    trap_stall_i   = 1'b0;
    jump_ex_i      = 1'b0;

    fd = $fopen("tb/pipeline_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file tb/pipeline_trace.txt");
      $display("tests failed");
    end else begin
      // reset held over four rising edges
      for (int i = 0; i < 4; i++) begin
        @(posedge clk);
        @(negedge clk);
        compare_vectors(6'h00, 6'h1f, 1'b0, 32'h0);
      end

      while (!$feof(fd) && !timed_out) begin
        guard++;
        if (guard > max_lines) begin
          timed_out = 1'b1;
        end else if ($fgets(line, fd) != 0) begin
          if (line.len() > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%h %h %h %h %d %d %d %h %h %h %h %h %h %h %h %h",
                        v, pc, ld, md, rs1, rs2, rd, mw, iw, tf, ts, jp,
                        exp_stall, exp_flush, exp_wb_valid, exp_wb_pc);
            if (n != 16) begin
              errors++;
              $display("malformed trace line: %s", line);
            end else begin
              @(posedge clk);
              rst            <= 1'b0;
              if_valid_i     <= v;
              if_pc_i        <= pc;
              if_is_load_i   <= ld;
              if_is_muldiv_i <= md;
              if_rs1_i       <= 5'(rs1);
              if_rs2_i       <= 5'(rs2);
              if_rd_i        <= 5'(rd);
              mem_wait_i     <= mw;
              if_wait_i      <= iw;
              trap_flush_i   <= tf;
              trap_stall_i   <= ts;
              jump_ex_i      <= jp;
              @(negedge clk);  // outputs settled mid-cycle
              compare_vectors(exp_stall, exp_flush, exp_wb_valid, exp_wb_pc);
            end
          end
        end
      end
      $fclose(fd);

      if (timed_out) begin
        $display("trace read did not reach end of file within %0d lines", max_lines);
        errors++;
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
    end
    $finish;
  end

endmodule

// ==== tb/pipeline_trace.txt ====
# one line per cycle: v pc ld md rs1 rs2 rd mem_wait if_wait trap_flush trap_stall jump
# then expected stall flush wb_valid wb_pc (pc, vectors hex; register indices decimal)
1 00000100 0 0 1 2 3 0 0 0 0 0 00 00 0 00000000
1 00000104 0 0 5 6 4 0 0 0 0 0 00 00 0 00000000
1 00000108 1 0 1 2 7 0 0 0 0 0 00 00 0 00000000
1 0000010c 0 0 7 0 8 0 0 0 0 0 00 00 0 00000000
1 00000110 0 0 9 10 11 0 0 0 0 0 03 04 1 00000100
1 00000110 0 0 9 10 11 0 0 0 0 0 00 00 1 00000104
1 00000114 1 0 1 2 0 0 0 0 0 0 00 00 1 00000108
1 00000118 0 0 0 0 12 0 0 0 0 0 00 00 0 00000000
1 0000011c 0 1 3 4 13 0 0 0 0 0 00 00 1 0000010c
1 00000120 0 0 15 16 14 0 0 0 0 0 00 00 1 00000110
1 00000124 0 0 18 19 17 0 0 0 0 0 07 08 1 00000114
1 00000124 0 0 18 19 17 0 0 0 0 0 07 08 1 00000118
1 00000124 0 0 18 19 17 0 0 0 0 0 07 08 0 00000000
1 00000124 0 0 18 19 17 0 0 0 0 0 07 08 0 00000000
1 00000124 0 0 18 19 17 0 0 0 0 0 00 00 0 00000000
1 00000128 0 0 21 22 20 0 0 0 0 0 00 00 0 00000000
1 0000012c 0 0 0 0 23 0 0 0 0 0 00 00 1 0000011c
1 00000130 0 0 1 2 24 0 0 0 0 1 02 06 1 00000120
1 00000200 0 0 26 27 25 0 0 0 0 0 00 00 1 00000124
1 00000204 0 0 29 30 28 0 0 0 0 0 00 00 1 00000128
1 00000208 0 0 1 2 1 0 0 1 0 0 02 0e 0 00000000
1 00000208 0 0 1 2 1 0 0 0 1 0 3f 0e 0 00000000
1 00000300 0 0 3 4 2 0 0 0 0 0 00 00 0 00000000
1 00000304 1 0 6 7 5 0 0 0 0 0 00 00 0 00000000
1 00000308 0 0 5 0 6 0 0 0 0 0 00 00 0 00000000
1 0000030c 0 0 9 10 8 1 0 0 0 1 0f 10 0 00000000
1 0000030c 0 0 9 10 8 1 0 0 0 0 0f 10 0 00000000
1 0000030c 0 0 9 10 8 0 0 0 0 0 03 04 0 00000000
1 0000030c 0 0 9 10 8 0 0 0 0 0 00 00 1 00000300
0 00000000 0 0 0 0 0 0 0 0 0 0 00 00 1 00000304
0 00000000 0 0 0 0 0 0 0 0 0 0 00 00 0 00000000
0 00000000 0 0 0 0 0 0 0 0 0 0 00 00 1 00000308
0 00000000 0 0 0 0 0 0 0 0 0 0 00 00 1 0000030c
0 00000000 0 0 0 0 0 0 0 0 0 0 00 00 0 00000000

// ==== filelist.f ====
+incdir+hw
hw/pipe_types_pkg.sv
hw/pipe_ctrl_pkg.sv
hw/hazard_unit.sv
hw/mul_div_sequencer.sv
hw/stage_tracker.sv
hw/pipeline_ctrl_top.sv
tb/pipeline_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: pipeline_ctrl

sources:
  - include_dirs:
      - hw
    files:
      - hw/pipe_types_pkg.sv
      - hw/pipe_ctrl_pkg.sv
      - hw/hazard_unit.sv
      - hw/mul_div_sequencer.sv
      - hw/stage_tracker.sv
      - hw/pipeline_ctrl_top.sv
  - target: test
    files:
      - tb/pipeline_ctrl_tb.sv
